/* hw/riscvPkg.sv */
package riscvPkg;

	// Major opcodes
	localparam logic [6:0] OpReg    = 7'b0110011;
	localparam logic [6:0] OpImm    = 7'b0010011;
	localparam logic [6:0] OpLoad   = 7'b0000011;
	localparam logic [6:0] OpStore  = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal    = 7'b1101111;
	localparam logic [6:0] OpJalr   = 7'b1100111;
	localparam logic [6:0] OpLui    = 7'b0110111;
	localparam logic [6:0] OpAuipc  = 7'b0010111;
	localparam logic [6:0] OpSystem = 7'b1110011;

	// Integer op funct3
	localparam logic [2:0] F3Add  = 3'b000;
	localparam logic [2:0] F3Sll  = 3'b001;
	localparam logic [2:0] F3Slt  = 3'b010;
	localparam logic [2:0] F3Sltu = 3'b011;
	localparam logic [2:0] F3Xor  = 3'b100;
	localparam logic [2:0] F3Srl  = 3'b101;
	localparam logic [2:0] F3Or   = 3'b110;
	localparam logic [2:0] F3And  = 3'b111;

	// Branch funct3
	localparam logic [2:0] F3Beq  = 3'b000;
	localparam logic [2:0] F3Bne  = 3'b001;
	localparam logic [2:0] F3Blt  = 3'b100;
	localparam logic [2:0] F3Bge  = 3'b101;
	localparam logic [2:0] F3Bltu = 3'b110;
	localparam logic [2:0] F3Bgeu = 3'b111;

	localparam logic [11:0] Funct12Ebreak = 12'h001;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor,
		AluSrl, AluSra, AluOr, AluAnd, AluPassB
	} aluOpT;

	typedef enum logic [1:0] {WbAlu, WbMem, WbPc4, WbImm} wbSelT;

	// Encoding matches load/store funct3[1:0]
	typedef enum logic [1:0] {SizeByte, SizeHalf, SizeWord} memSizeT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmtT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iFmtT;

	typedef struct packed {
		logic [6:0] imm11to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4to0;
		logic [6:0] opcode;
	} sFmtT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bFmtT;

	typedef struct packed {
		logic [19:0] imm31to12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uFmtT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFmtT;

	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		sFmtT sFmt;
		bFmtT bFmt;
		uFmtT uFmt;
		jFmtT jFmt;
	} instrT;

endpackage

/* hw/riscvControl.sv */
module riscvControl (
	input  riscvPkg::instrT   instr,
	output riscvPkg::aluOpT   aluOp,
	output logic              aluSrcImm,
	output logic              aluSrcPc,
	output riscvPkg::wbSelT   wbSel,
	output logic              regWrite,
	output logic              memWrite,
	output riscvPkg::memSizeT memSize,
	output logic              memUnsigned,
	output logic              isBranch,
	output logic              isJal,
	output logic              isJalr,
	output logic              haltReq
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       altOp;
	riscvPkg::aluOpT intOp;

	assign opcode = instr.rFmt.opcode;
	assign funct3 = instr.rFmt.funct3;
	assign altOp  = instr.rFmt.funct7[5];

	// Shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			riscvPkg::F3Add:  intOp = (altOp && opcode == riscvPkg::OpReg) ?
				riscvPkg::AluSub : riscvPkg::AluAdd; // No SUBI
			riscvPkg::F3Sll:  intOp = riscvPkg::AluSll;
			riscvPkg::F3Slt:  intOp = riscvPkg::AluSlt;
			riscvPkg::F3Sltu: intOp = riscvPkg::AluSltu;
			riscvPkg::F3Xor:  intOp = riscvPkg::AluXor;
			riscvPkg::F3Srl:  intOp = altOp ? riscvPkg::AluSra : riscvPkg::AluSrl;
			riscvPkg::F3Or:   intOp = riscvPkg::AluOr;
			default:          intOp = riscvPkg::AluAnd;
		endcase
	end

	always_comb begin
		aluOp       = riscvPkg::AluAdd;
		aluSrcImm   = 1'b0;
		aluSrcPc    = 1'b0;
		wbSel       = riscvPkg::WbAlu;
		regWrite    = 1'b0;
		memWrite    = 1'b0;
		memSize     = riscvPkg::memSizeT'(instr.iFmt.funct3[1:0]);
		memUnsigned = instr.iFmt.funct3[2]; // LBU, LHU
		isBranch    = 1'b0;
		isJal       = 1'b0;
		isJalr      = 1'b0;
		haltReq     = 1'b0;
		case (opcode)
			riscvPkg::OpReg: begin
				aluOp    = intOp;
				regWrite = 1'b1;
			end
			riscvPkg::OpImm: begin
				aluOp     = intOp;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			riscvPkg::OpLoad: begin
				aluSrcImm = 1'b1;
				wbSel     = riscvPkg::WbMem;
				regWrite  = 1'b1;
			end
			riscvPkg::OpStore: begin
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
			end
			riscvPkg::OpBranch: isBranch = 1'b1; // Compare rs1 and rs2
			riscvPkg::OpJal: begin
				isJal    = 1'b1;
				wbSel    = riscvPkg::WbPc4;
				regWrite = 1'b1;
			end
			riscvPkg::OpJalr: begin
				isJalr    = 1'b1;
				aluSrcImm = 1'b1; // Target is rs1 + imm
				wbSel     = riscvPkg::WbPc4;
				regWrite  = 1'b1;
			end
			riscvPkg::OpLui: begin
				aluOp     = riscvPkg::AluPassB;
				aluSrcImm = 1'b1;
				wbSel     = riscvPkg::WbImm;
				regWrite  = 1'b1;
			end
			riscvPkg::OpAuipc: begin
				aluSrcPc  = 1'b1;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			riscvPkg::OpSystem:
				haltReq = (instr.iFmt.funct3 == 3'b000) &&
					(instr.iFmt.imm == riscvPkg::Funct12Ebreak);
			default: ; // Unknown opcode runs as a no-op
		endcase
	end

endmodule

/* hw/riscvImmGen.sv */
module riscvImmGen (
	input  riscvPkg::instrT instr,
	output logic [31:0]     imm
);

	logic sign;

	assign sign = instr.iFmt.imm[11]; // Always instruction bit 31

	always_comb begin
		case (instr.rFmt.opcode)
			riscvPkg::OpImm,
			riscvPkg::OpLoad,
			riscvPkg::OpJalr:
				imm = {{20{sign}}, instr.iFmt.imm};
			riscvPkg::OpStore:
				imm = {{20{sign}}, instr.sFmt.imm11to5, instr.sFmt.imm4to0};
			riscvPkg::OpBranch:
				imm = {
					{20{sign}},
					instr.bFmt.imm11,
					instr.bFmt.imm10to5,
					instr.bFmt.imm4to1,
					1'b0
				};
			riscvPkg::OpLui,
			riscvPkg::OpAuipc:
				imm = {instr.uFmt.imm31to12, 12'b0};
			riscvPkg::OpJal:
				imm = {
					{12{sign}},
					instr.jFmt.imm19to12,
					instr.jFmt.imm11,
					instr.jFmt.imm10to1,
					1'b0
				};
			default:
				imm = 32'b0; // R-type and system
		endcase
	end

endmodule

/* hw/riscvAlu.sv */
module riscvAlu (
	input  logic [31:0]     opA,
	input  logic [31:0]     opB,
	input  riscvPkg::aluOpT aluOp,
	input  logic [2:0]      funct3,
	output logic [31:0]     aluResult,
	output logic            branchTaken
);

	logic [4:0] shamt;
	logic       lessSigned;
	logic       lessUnsigned;
	logic       equal;

	assign shamt        = opB[4:0];
	assign lessSigned   = $signed(opA) < $signed(opB);
	assign lessUnsigned = opA < opB;
	assign equal        = opA == opB;

	always_comb begin
		case (aluOp)
			riscvPkg::AluAdd:   aluResult = opA + opB;
			riscvPkg::AluSub:   aluResult = opA - opB;
			riscvPkg::AluSll:   aluResult = opA << shamt;
			riscvPkg::AluSlt:   aluResult = {31'b0, lessSigned};
			riscvPkg::AluSltu:  aluResult = {31'b0, lessUnsigned};
			riscvPkg::AluXor:   aluResult = opA ^ opB;
			riscvPkg::AluSrl:   aluResult = opA >> shamt;
			riscvPkg::AluSra:   aluResult = $unsigned($signed(opA) >>> shamt);
			riscvPkg::AluOr:    aluResult = opA | opB;
			riscvPkg::AluAnd:   aluResult = opA & opB;
			riscvPkg::AluPassB: aluResult = opB;
			default:            aluResult = 32'b0;
		endcase
	end

	// Branch condition on rs1/rs2 directly
	always_comb begin
		case (funct3)
			riscvPkg::F3Beq:  branchTaken = equal;
			riscvPkg::F3Bne:  branchTaken = !equal;
			riscvPkg::F3Blt:  branchTaken = lessSigned;
			riscvPkg::F3Bge:  branchTaken = !lessSigned;
			riscvPkg::F3Bltu: branchTaken = lessUnsigned;
			riscvPkg::F3Bgeu: branchTaken = !lessUnsigned;
			default:          branchTaken = 1'b0;
		endcase
	end

endmodule

/* hw/riscvPc.sv */
module riscvPc #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,
	input  logic                 isBranch,
	input  logic                 branchTaken,
	input  logic                 isJal,
	input  logic                 isJalr,
	input  logic                 haltReq,
	input  logic [31:0]          imm,
	input  logic [31:0]          aluResult,
	output logic [AddrWidth-1:0] pc,
	output logic [AddrWidth-1:0] pcPlus4,
	output logic                 HALT,
	output logic [31:0]          NUM_INST,
	output logic                 I_MEM_CSN,
	output logic                 D_MEM_CSN
);

	logic [AddrWidth-1:0] nextPc;
	logic                 csn;

	assign pcPlus4   = pc + AddrWidth'(4);
	assign I_MEM_CSN = csn;
	assign D_MEM_CSN = csn;

	always_comb begin
		if (isJalr)
			nextPc = aluResult[AddrWidth-1:0] & ~AddrWidth'(1);
		else if (isJal || (isBranch && branchTaken))
			nextPc = pc + imm[AddrWidth-1:0];
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc       <= '0;
			HALT     <= 1'b0;
			NUM_INST <= 32'b0;
			csn      <= 1'b1;
		end else begin
			csn <= 1'b0;
			// First cycle after reset is idle while memories are deselected
			if (!csn && !HALT) begin
				pc       <= nextPc;
				NUM_INST <= NUM_INST + 32'd1;
				if (haltReq)
					HALT <= 1'b1; // EBREAK still counted
			end
		end
	end

endmodule

/* hw/riscvLsu.sv */
module riscvLsu #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,
	input  logic                 HALT,
	input  logic                 memWrite,
	input  riscvPkg::memSizeT    memSize,
	input  logic                 memUnsigned,
	input  riscvPkg::wbSelT      wbSel,
	input  logic                 regWrite,
	input  logic [31:0]          aluResult,
	input  logic [31:0]          storeData,
	input  logic [AddrWidth-1:0] pcPlus4,
	input  logic [31:0]          imm,
	input  logic [31:0]          D_MEM_DI,
	output logic [31:0]          D_MEM_DOUT,
	output logic [3:0]           D_MEM_BE,
	output logic                 D_MEM_WEN,
	output logic                 RF_WE,
	output logic [31:0]          RF_WD
);

	logic        quiet;
	logic        writeOk;
	logic [1:0]  byteOff;
	logic [31:0] laneWord;
	logic [31:0] loadData;

	always_ff @(posedge CLK) begin
		quiet <= RSTn; // High for one cycle after reset
	end

	assign writeOk   = !RSTn && !HALT && !quiet;
	assign D_MEM_WEN = !(memWrite && writeOk);
	assign RF_WE     = regWrite && writeOk;

	assign byteOff  = aluResult[1:0];
	assign laneWord = D_MEM_DI >> {byteOff, 3'b000};

	always_comb begin
		case (memSize)
			riscvPkg::SizeByte: begin
				D_MEM_DOUT = {4{storeData[7:0]}};
				D_MEM_BE   = 4'b0001 << byteOff;
				loadData   = {{24{!memUnsigned && laneWord[7]}}, laneWord[7:0]};
			end
			riscvPkg::SizeHalf: begin
				D_MEM_DOUT = {2{storeData[15:0]}};
				D_MEM_BE   = 4'b0011 << {byteOff[1], 1'b0};
				loadData   = {{16{!memUnsigned && laneWord[15]}}, laneWord[15:0]};
			end
			default: begin
				D_MEM_DOUT = storeData;
				D_MEM_BE   = 4'b1111;
				loadData   = D_MEM_DI;
			end
		endcase
	end

	always_comb begin
		case (wbSel)
			riscvPkg::WbMem: RF_WD = loadData;
			riscvPkg::WbPc4: RF_WD = {{(32-AddrWidth){1'b0}}, pcPlus4}; // Link address
			riscvPkg::WbImm: RF_WD = imm;
			default:         RF_WD = aluResult;
		endcase
	end

endmodule

/* hw/riscvTop.sv */
module riscvTop #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,

	output logic                 I_MEM_CSN,
	input  logic [31:0]          I_MEM_DI,
	output logic [AddrWidth-1:0] I_MEM_ADDR, // Byte address

	output logic                 D_MEM_CSN,
	input  logic [31:0]          D_MEM_DI,
	output logic [31:0]          D_MEM_DOUT,
	output logic [AddrWidth-1:0] D_MEM_ADDR, // Byte address
	output logic                 D_MEM_WEN,
	output logic [3:0]           D_MEM_BE,

	output logic                 RF_WE,
	output logic [4:0]           RF_RA1,
	output logic [4:0]           RF_RA2,
	output logic [4:0]           RF_WA1,
	input  logic [31:0]          RF_RD1,
	input  logic [31:0]          RF_RD2,
	output logic [31:0]          RF_WD,

	output logic                 HALT,
	output logic [31:0]          NUM_INST,
	output logic [31:0]          OUTPUT_PORT
);

	riscvPkg::instrT      instr;
	riscvPkg::aluOpT      aluOp;
	riscvPkg::wbSelT      wbSel;
	riscvPkg::memSizeT    memSize;
	logic                 aluSrcImm;
	logic                 aluSrcPc;
	logic                 regWrite;
	logic                 memWrite;
	logic                 memUnsigned;
	logic                 isBranch;
	logic                 isJal;
	logic                 isJalr;
	logic                 haltReq;
	logic [31:0]          imm;
	logic [31:0]          aluResult;
	logic                 branchTaken;
	logic [AddrWidth-1:0] pc;
	logic [AddrWidth-1:0] pcPlus4;

	assign instr       = riscvPkg::instrT'(I_MEM_DI);
	assign RF_RA1      = instr.rFmt.rs1;
	assign RF_RA2      = instr.rFmt.rs2;
	assign RF_WA1      = instr.rFmt.rd;
	assign I_MEM_ADDR  = pc;
	assign D_MEM_ADDR  = aluResult[AddrWidth-1:0];
	assign OUTPUT_PORT = RF_WD;

	riscvControl control_i (
		.instr(instr), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.wbSel(wbSel), .regWrite(regWrite), .memWrite(memWrite), .memSize(memSize),
		.memUnsigned(memUnsigned), .isBranch(isBranch), .isJal(isJal),
		.isJalr(isJalr), .haltReq(haltReq)
	);

	riscvImmGen immGen_i (.instr(instr), .imm(imm));

	riscvAlu alu_i (
		.opA(aluSrcPc ? {{(32-AddrWidth){1'b0}}, pc} : RF_RD1), // AUIPC uses pc
		.opB(aluSrcImm ? imm : RF_RD2),
		.aluOp(aluOp),
		.funct3(instr.bFmt.funct3),
		.aluResult(aluResult),
		.branchTaken(branchTaken)
	);

	riscvPc #(.AddrWidth(AddrWidth)) pc_i (
		.CLK(CLK), .RSTn(RSTn), .isBranch(isBranch), .branchTaken(branchTaken),
		.isJal(isJal), .isJalr(isJalr), .haltReq(haltReq), .imm(imm),
		.aluResult(aluResult), .pc(pc), .pcPlus4(pcPlus4), .HALT(HALT),
		.NUM_INST(NUM_INST), .I_MEM_CSN(I_MEM_CSN), .D_MEM_CSN(D_MEM_CSN)
	);

	riscvLsu #(.AddrWidth(AddrWidth)) lsu_i (
		.CLK(CLK), .RSTn(RSTn), .HALT(HALT), .memWrite(memWrite),
		.memSize(memSize), .memUnsigned(memUnsigned), .wbSel(wbSel),
		.regWrite(regWrite), .aluResult(aluResult), .storeData(RF_RD2),
		.pcPlus4(pcPlus4), .imm(imm), .D_MEM_DI(D_MEM_DI),
		.D_MEM_DOUT(D_MEM_DOUT), .D_MEM_BE(D_MEM_BE), .D_MEM_WEN(D_MEM_WEN),
		.RF_WE(RF_WE), .RF_WD(RF_WD)
	);

endmodule

/* dv/riscvTbMem.sv */
module riscvTbMem (
	input  logic        CLK,
	input  logic        init, // Refill data memory and clear registers

	input  logic        I_MEM_CSN,
	input  logic [11:0] I_MEM_ADDR,
	output logic [31:0] I_MEM_DI,

	input  logic        D_MEM_CSN,
	input  logic [11:0] D_MEM_ADDR,
	input  logic [31:0] D_MEM_DOUT,
	input  logic        D_MEM_WEN,
	input  logic [3:0]  D_MEM_BE,
	output logic [31:0] D_MEM_DI,

	input  logic        RF_WE,
	input  logic [4:0]  RF_RA1,
	input  logic [4:0]  RF_RA2,
	input  logic [4:0]  RF_WA1,
	input  logic [31:0] RF_WD,
	output logic [31:0] RF_RD1,
	output logic [31:0] RF_RD2
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] imem [1024]; // Loaded by the testbench
	logic [31:0] dmem [1024];
	logic [31:0] regs [32];

	assign I_MEM_DI = I_MEM_CSN ? 32'h0 : imem[I_MEM_ADDR[11:2]];
	assign D_MEM_DI = dmem[D_MEM_ADDR[11:2]];
	assign RF_RD1   = regs[RF_RA1]; // x0 is never written
	assign RF_RD2   = regs[RF_RA2];

	always @(posedge CLK) begin
		if (init) begin
			// Fill word depends on the whole word address
			for (int i = 0; i < 1024; i++)
				dmem[i] <= {6'h2D, i[9:0], 6'h17, ~i[9:0]};
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end else begin
			if (!D_MEM_CSN && !D_MEM_WEN) begin
				for (int b = 0; b < 4; b++) begin
					if (D_MEM_BE[b])
						dmem[D_MEM_ADDR[11:2]][8*b +: 8] <= D_MEM_DOUT[8*b +: 8];
				end
			end
			if (RF_WE && RF_WA1 != 5'd0)
				regs[RF_WA1] <= RF_WD;
		end
	end

endmodule

/* dv/riscvTb.sv */
module riscvTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int OpI      = 'h13;
	localparam int OpLd     = 'h03;
	localparam int OpLui    = 'h37;
	localparam int OpAuipc  = 'h17;
	localparam int OpJalr   = 'h67;
	localparam int DataBase = 'h100;
	localparam logic [31:0] Ebreak = 32'h0010_0073;

	// All runs with reset and idle cycles, rounded up
	localparam int ProgramCycles = 400;
	localparam int CycleLimit    = ProgramCycles + 2000;

	logic        CLK;
	logic        RSTn;
	logic        init;
	logic        I_MEM_CSN;
	logic [31:0] I_MEM_DI;
	logic [11:0] I_MEM_ADDR;
	logic        D_MEM_CSN;
	logic [31:0] D_MEM_DI;
	logic [31:0] D_MEM_DOUT;
	logic [11:0] D_MEM_ADDR;
	logic        D_MEM_WEN;
	logic [3:0]  D_MEM_BE;
	logic        RF_WE;
	logic [4:0]  RF_RA1;
	logic [4:0]  RF_RA2;
	logic [4:0]  RF_WA1;
	logic [31:0] RF_RD1;
	logic [31:0] RF_RD2;
	logic [31:0] RF_WD;
	logic        HALT;
	logic [31:0] NUM_INST;
	logic [31:0] OUTPUT_PORT;

	int          cycles = 0;
	bit          watchWrites = 1'b0; // Registers written once each
	int          writesSeen = 0;
	logic [31:0] prog[$];
	logic [31:0] expMem [1024];
	logic [31:0] expReg [32];

	riscvTop #(.AddrWidth(12)) dut_i (.*);
	riscvTbMem mem_i (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("Simulation failed");
			$fatal(1, "Timeout: tests still running after %0d cycles", cycles);
		end
	end

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "Check of %s failed", name);
		end
	endtask

	// Write data on the output port as each register write retires
	always @(posedge CLK) begin
		if (watchWrites && RF_WE === 1'b1 && RF_WA1 != 5'd0) begin
			compare("OUTPUT_PORT", OUTPUT_PORT, expReg[RF_WA1]);
			writesSeen++;
		end
	end

	// RV32I instruction encoders
	function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd, int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] sType(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] bType(int imm, int rs1, int rs2, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] uType(int imm20, int rd, int op);
		return {imm20[19:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] jType(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
	endfunction

	function automatic logic [31:0] addi(int rd, int rs1, int imm);
		return iType(imm, rs1, 0, rd, OpI);
	endfunction

	function automatic logic [31:0] initialWord(int i);
		return {6'h2D, i[9:0], 6'h17, ~i[9:0]};
	endfunction

	function automatic int pcNext();
		return prog.size() * 4;
	endfunction

	task automatic emit(logic [31:0] w);
		prog.push_back(w);
	endtask

	task automatic loadConst(int rd, logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12; // ADDI sign-extends the low part
		emit(uType(int'(hi), rd, OpLui));
		emit(addi(rd, rd, int'(v)));
	endtask

	task automatic modelStore(int addr, logic [31:0] data, int nBytes);
		for (int k = 0; k < nBytes; k++)
			expMem[(addr + k) / 4][8*((addr + k) % 4) +: 8] = data[8*k +: 8];
	endtask

	function automatic logic [31:0] modelLoad(int addr, int nBytes, bit isUnsigned);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < nBytes; k++)
			v[8*k +: 8] = expMem[(addr + k) / 4][8*((addr + k) % 4) +: 8];
		if (!isUnsigned && nBytes < 4 && v[8*nBytes-1])
			v = v | (32'hFFFF_FFFF << (8*nBytes));
		return v;
	endfunction

	task automatic newProgram();
		prog.delete();
		for (int k = 0; k < 1024; k++)
			expMem[k] = initialWord(k);
		for (int k = 0; k < 32; k++)
			expReg[k] = '0;
	endtask

	task automatic resetCore(bit clearState);
		@(posedge CLK);
		#1;
		RSTn = 1'b1;
		init = clearState;
		@(posedge CLK);
		#1;
		init = 1'b0;
		repeat (4) @(posedge CLK); // Five reset edges in total
		#1;
		RSTn = 1'b0;
	endtask

	task automatic waitHalt();
		do begin
			@(posedge CLK);
			#1;
		end while (HALT !== 1'b1);
	endtask

	task automatic runProgram();
		for (int k = 0; k < 1024; k++)
			mem_i.imem[k] = (k < prog.size()) ? prog[k] : Ebreak; // Stray jumps halt
		resetCore(1'b1);
		waitHalt();
	endtask

	task automatic verifyRegs();
		for (int n = 0; n < 32; n++)
			compare($sformatf("x%0d", n), mem_i.regs[n], expReg[n]);
	endtask

	task automatic verifyMemory();
		for (int k = 0; k < 1024; k++)
			compare($sformatf("dmem[0x%03h]", k * 4), mem_i.dmem[k], expMem[k]);
	endtask

	task automatic arithLogic();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immX;
		int          imm;
		a    = $urandom() & 32'h7FFF_FFFF; // Positive
		b    = $urandom() | 32'h8000_0000; // Negative
		imm  = int'($urandom() % 4096) - 2048;
		immX = imm;
		newProgram();
		loadConst(1, a);
		loadConst(2, b);
		emit(rType(0, 2, 1, 0, 3));
		emit(rType('h20, 2, 1, 0, 4)); // SUB
		emit(rType('h20, 1, 2, 5, 5)); // SRA
		emit(rType(0, 1, 2, 5, 6));
		emit(rType(0, 2, 1, 1, 7));
		emit(rType(0, 1, 2, 2, 8));
		emit(rType(0, 1, 2, 3, 9));
		emit(rType(0, 2, 1, 4, 10));
		emit(rType(0, 2, 1, 6, 11));
		emit(rType(0, 2, 1, 7, 12));
		emit(addi(13, 1, imm));
		emit(iType('h407, 2, 5, 14, OpI)); // SRAI 7
		emit(iType(imm, 2, 2, 15, OpI));
		emit(iType(imm, 1, 3, 16, OpI));
		emit(iType(imm, 2, 4, 17, OpI));
		emit(iType(imm, 1, 6, 18, OpI));
		emit(iType(imm, 2, 7, 19, OpI));
		emit(iType(13, 1, 1, 20, OpI));
		emit(iType(9, 2, 5, 21, OpI));
		emit(addi(0, 0, 5)); // x0 stays zero
		emit(Ebreak);
		expReg[1]  = a;
		expReg[2]  = b;
		expReg[3]  = a + b;
		expReg[4]  = a - b;
		expReg[5]  = $signed(b) >>> a[4:0];
		expReg[6]  = b >> a[4:0];
		expReg[7]  = a << b[4:0];
		expReg[8]  = {31'b0, $signed(b) < $signed(a)};
		expReg[9]  = {31'b0, b < a};
		expReg[10] = a ^ b;
		expReg[11] = a | b;
		expReg[12] = a & b;
		expReg[13] = a + immX;
		expReg[14] = $signed(b) >>> 7;
		expReg[15] = {31'b0, $signed(b) < $signed(immX)};
		expReg[16] = {31'b0, a < immX};
		expReg[17] = b ^ immX;
		expReg[18] = a | immX;
		expReg[19] = b & immX;
		expReg[20] = a << 13;
		expReg[21] = b >> 9;
		runProgram();
		verifyRegs();
		compare("NUM_INST", NUM_INST, prog.size());
	endtask

	task automatic storeAt(int off, int f3, logic [31:0] data);
		emit(sType(off, 2, 1, f3));
		modelStore(DataBase + off, data, 1 << f3);
	endtask

	task automatic loadAt(int rd, int off, int f3);
		emit(iType(off, 1, f3, rd, OpLd));
		expReg[rd] = modelLoad(DataBase + off, 1 << (f3 % 4), f3 >= 4);
	endtask

	task automatic loadStore();
		logic [31:0] d;
		d = 32'h3C5A_F081;
		newProgram();
		emit(addi(1, 0, DataBase));
		loadConst(2, d);
		expReg[1] = DataBase;
		expReg[2] = d;
		storeAt(0, 0, d);
		storeAt(5, 0, d);
		storeAt(10, 0, d);
		storeAt(15, 0, d);
		storeAt(16, 1, d);
		storeAt(22, 1, d);
		storeAt(24, 2, d);
		loadAt(3, 5, 0);
		loadAt(4, 15, 4);
		loadAt(5, 10, 0);
		loadAt(6, 33, 0); // Untouched words from here
		loadAt(7, 35, 4);
		loadAt(8, 22, 1);
		loadAt(9, 16, 5);
		loadAt(10, 34, 1);
		loadAt(11, 24, 2);
		loadAt(12, 36, 2);
		loadAt(13, 0, 4);
		emit(Ebreak);
		runProgram();
		verifyRegs();
		verifyMemory();
		compare("NUM_INST", NUM_INST, prog.size());
	endtask

	task automatic takenBranch(int f3, int ra, int rb);
		emit(bType(8, ra, rb, f3));
		emit(addi(31, 31, 1)); // Must be skipped
		emit(addi(29, 29, 1));
	endtask

	task automatic fallThrough(int f3, int ra, int rb);
		emit(bType(8, ra, rb, f3));
		emit(addi(30, 30, 1));
	endtask

	task automatic controlFlow();
		int jalPc;
		int jalrPc;
		int target;
		newProgram();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, -3));
		emit(addi(3, 0, 5));
		takenBranch(0, 1, 3);
		fallThrough(0, 1, 2);
		takenBranch(1, 1, 2);
		fallThrough(1, 1, 3);
		takenBranch(4, 2, 1);
		fallThrough(4, 1, 2);
		takenBranch(5, 1, 2);
		fallThrough(5, 2, 1);
		takenBranch(6, 1, 2);
		fallThrough(6, 2, 1);
		takenBranch(7, 2, 1);
		fallThrough(7, 1, 2);
		emit(addi(5, 0, 3)); // Backward loop, three passes
		emit(addi(6, 6, 1));
		emit(addi(5, 5, -1));
		emit(bType(-8, 5, 0, 1));
		jalPc = pcNext();
		emit(jType(8, 7));
		emit(addi(31, 31, 1));
		emit(addi(29, 29, 1));
		target = pcNext() + 12;
		emit(addi(8, 0, target));
		jalrPc = pcNext();
		emit(iType(1, 8, 0, 9, OpJalr)); // Odd target, bit 0 dropped
		emit(addi(31, 31, 1));
		emit(addi(29, 29, 1));
		emit(Ebreak);
		expReg[1]  = 5;
		expReg[2]  = 32'hFFFF_FFFD;
		expReg[3]  = 5;
		expReg[6]  = 3;
		expReg[7]  = jalPc + 4;
		expReg[8]  = target;
		expReg[9]  = jalrPc + 4;
		expReg[29] = 8;
		expReg[30] = 6;
		runProgram();
		verifyRegs();
		// Eight skipped instructions, two extra loop passes
		compare("NUM_INST", NUM_INST, prog.size() - 8 + 6);
	endtask

	task automatic upperImm();
		int pcA;
		int pcB;
		newProgram();
		repeat (3) emit(addi(0, 0, 0));
		emit(uType('hABCDE, 1, OpLui));
		pcA = pcNext();
		emit(uType('h12345, 2, OpAuipc));
		pcB = pcNext();
		emit(uType('hFFFFF, 3, OpAuipc));
		emit(Ebreak);
		expReg[1] = 32'hABCD_E000;
		expReg[2] = 32'h1234_5000 + pcA;
		expReg[3] = 32'hFFFF_F000 + pcB;
		writesSeen  = 0;
		watchWrites = 1'b1;
		runProgram();
		watchWrites = 1'b0;
		compare("OUTPUT_PORT writes", writesSeen, 3);
		verifyRegs();
		compare("NUM_INST", NUM_INST, prog.size());
	endtask

	task automatic haltCount();
		logic [11:0] pcHold;
		newProgram();
		emit(addi(1, 0, 7));
		emit(addi(2, 0, 'h40));
		emit(sType('h300, 1, 0, 2));
		emit(Ebreak);
		emit(addi(1, 1, 100)); // Never executed
		emit(sType('h304, 1, 0, 2));
		emit(addi(3, 0, 1));
		expReg[1] = 7;
		expReg[2] = 'h40;
		modelStore('h300, 32'd7, 4);
		runProgram();
		pcHold = I_MEM_ADDR;
		compare("NUM_INST", NUM_INST, 4);
		repeat (20) @(posedge CLK);
		#1;
		compare("HALT", {31'b0, HALT}, 32'd1);
		compare("NUM_INST", NUM_INST, 4);
		compare("I_MEM_ADDR", {20'b0, I_MEM_ADDR}, {20'b0, pcHold});
		verifyRegs();
		verifyMemory();
	endtask

	task automatic midReset();
		newProgram();
		emit(addi(1, 0, 10));
		emit(addi(2, 0, 0));
		emit(rType(0, 1, 2, 0, 2));
		emit(addi(1, 1, -1));
		emit(bType(-8, 1, 0, 1));
		emit(sType('h200, 2, 0, 2));
		emit(Ebreak);
		expReg[2] = 55; // Sum of 1 to 10
		modelStore('h200, 32'd55, 4);
		runProgram();
		verifyRegs();
		verifyMemory();
		compare("NUM_INST", NUM_INST, 34);
		// Restart from a fresh state, then interrupt inside the loop
		resetCore(1'b1);
		repeat (15) @(posedge CLK);
		#1;
		compare("HALT", {31'b0, HALT}, 32'd0);
		resetCore(1'b0);
		compare("HALT", {31'b0, HALT}, 32'd0);
		compare("NUM_INST", NUM_INST, 0);
		compare("I_MEM_ADDR", {20'b0, I_MEM_ADDR}, 32'd0);
		waitHalt();
		verifyRegs();
		verifyMemory();
		compare("NUM_INST", NUM_INST, 34);
	endtask

	initial begin
		RSTn = 1'b1;
		init = 1'b0;
		void'($urandom(22));
		arithLogic();
		loadStore();
		controlFlow();
		upperImm();
		haltCount();
		midReset();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* sim.f */
hw/riscvPkg.sv
hw/riscvControl.sv
hw/riscvImmGen.sv
hw/riscvAlu.sv
hw/riscvPc.sv
hw/riscvLsu.sv
hw/riscvTop.sv
dv/riscvTbMem.sv
dv/riscvTb.sv

/* run.sh */
#!/bin/sh
# Build and run the riscvTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f sim.f --top-module riscvTb -o simv

./obj_dir/simv
